// File: source/tx_params.svh
`ifndef TX_PARAMS_SVH
`define TX_PARAMS_SVH

// Parallel word width, one word per 16 bit slots
`define TX_WORD_W 16

// Quarter-rate nibble width
`define TX_NIBBLE_W 4

// Largest skew code, also sets the delay line depth
`define TX_DELAY_MAX 7

// Fixed serial latency at delay code 0:
// hr register, qr load, driver register
`define TX_LAT_BASE 3

`endif

// File: source/tx_pkg.sv
`include "tx_params.svh"

package tx_pkg;

    // Parallel word as it comes from the source
    typedef logic [`TX_WORD_W-1:0] word_t;

    // One quarter of the word, MSB goes out first
    typedef logic [`TX_NIBBLE_W-1:0] nibble_t;

    // Bit slot within a word, 0 to 15
    typedef logic [$clog2(`TX_WORD_W)-1:0] slot_t;

    // Skew code in bit slots, 0 to 7
    typedef logic [$clog2(`TX_DELAY_MAX+1)-1:0] delay_t;

endpackage

// File: source/tx_ctrl_if.sv
`timescale 1ns/1ps

`default_nettype none

interface tx_ctrl_if;
    import tx_pkg::*;

    delay_t delay_code;   // Skew code, taken on delay_valid
    logic   delay_valid;  // Single-cycle update strobe
    logic   drv_en;       // Driver enable, level
    logic   pol_inv;      // Swap p and n legs, level

    // Driving side, fed from the top-level pins
    modport src (
        output delay_code,
        output delay_valid,
        output drv_en,
        output pol_inv
    );

    // Skew and driver stage
    modport sink (
        input delay_code,
        input delay_valid,
        input drv_en,
        input pol_inv
    );

endinterface

`default_nettype wire

// File: source/tx_clk_div.sv
`timescale 1ns/1ps

`default_nettype none

`include "tx_params.svh"

module tx_clk_div (
    input wire logic mdll_clk,   // Bit-rate clock
    input wire logic rst,        // Sync reset, active high
    output tx_pkg::slot_t slot,  // Bit slot within the current word
    output logic word_req        // One-cycle request for the next word
);
    import tx_pkg::*;

    // Slot just before the last one of a word
    localparam slot_t SLOT_PRE = slot_t'(`TX_WORD_W - 2);

    // Free-running slot counter, wraps every word
    always_ff @(posedge mdll_clk) begin
        if (rst) begin
            slot <= '0;
        end else begin
            slot <= slot + 1'b1;
        end
    end

    // Request registered one slot early so it lines up with slot 15
    always_ff @(posedge mdll_clk) begin
        if (rst) begin
            word_req <= 1'b0;
        end else begin
            word_req <= (slot == SLOT_PRE);  // High exactly while slot is 15
        end
    end

    // Request is a strobe, never held over two slots
    a_req_single: assert property (@(posedge mdll_clk) disable iff (rst)
        word_req |=> !word_req)
        else $error("word_req high for two consecutive cycles");

endmodule

`default_nettype wire

// File: source/hr_16t4_mux.sv
`timescale 1ns/1ps

`default_nettype none

`include "tx_params.svh"

module hr_16t4_mux (
    input wire logic mdll_clk,       // Bit-rate clock
    input wire logic rst,            // Sync reset, active high
    input wire tx_pkg::word_t din,   // Parallel word, valid while word_req is high
    input wire tx_pkg::slot_t slot,  // Bit slot from the divider
    output tx_pkg::nibble_t nibble   // Nibble for the quarter-rate stage
);
    import tx_pkg::*;

    localparam int N_NIB = `TX_WORD_W / `TX_NIBBLE_W;  // Nibbles per word
    localparam int B_W = $clog2(`TX_NIBBLE_W);          // Slot bits within a quarter
    localparam int Q_W = $clog2(N_NIB);                 // Slot bits picking the quarter

    word_t          word_q;          // Word held for the whole word time
    nibble_t        reord [N_NIB];   // Word split into nibbles, send order
    logic [Q_W-1:0] q_sel;           // Current quarter
    logic           quarter_start;   // Slot 0, 4, 8 or 12
    logic           word_load;       // Slot 15, edge E0 follows

    assign word_load = (slot == '1);
    assign quarter_start = (slot[B_W-1:0] == '0);
    assign q_sel = slot[B_W +: Q_W];

    // Interleave
    // nibble q carries din[15-q], din[11-q], din[7-q], din[3-q], first bit in MSB
    always_comb begin
        for (int q = 0; q < N_NIB; q++) begin
            for (int i = 0; i < `TX_NIBBLE_W; i++) begin
                reord[q][`TX_NIBBLE_W-1-i] = word_q[`TX_WORD_W-1-q-N_NIB*i];
            end
        end
    end

    // Word capture at E0, nibble q out at E0+1+4q
    always_ff @(posedge mdll_clk) begin
        if (rst) begin
            word_q <= '0;
            nibble <= '0;
        end else begin
            if (word_load) begin
                word_q <= din;  // Sampled once per word
            end
            if (quarter_start) begin
                nibble <= reord[q_sel];  // Next nibble each quarter
            end
        end
    end

    // One word sample per word time
    a_load_apart: assert property (@(posedge mdll_clk) disable iff (rst)
        word_load |=> !word_load[*(`TX_WORD_W-1)])
        else $error("Word sampled twice within one word time");

endmodule

`default_nettype wire

// File: source/qr_4t1_mux.sv
`timescale 1ns/1ps

`default_nettype none

`include "tx_params.svh"

module qr_4t1_mux (
    input wire logic mdll_clk,          // Bit-rate clock
    input wire logic rst,               // Sync reset, active high
    input wire tx_pkg::nibble_t nibble, // Nibble from the half-rate stage
    input wire tx_pkg::slot_t slot,     // Bit slot from the divider
    output logic ser_bit                // Serial bit, one per slot
);
    import tx_pkg::*;

    localparam int B_W = $clog2(`TX_NIBBLE_W);  // Slot bits within a quarter

    nibble_t shreg;  // Load-and-shift register
    logic    load;

    // One slot after the quarter boundary, nibble is settled by then
    assign load = (slot[B_W-1:0] == B_W'(1));

    always_ff @(posedge mdll_clk) begin
        if (rst) begin
            shreg <= '0;
        end else if (load) begin
            shreg <= nibble;
        end else begin
            shreg <= {shreg[`TX_NIBBLE_W-2:0], 1'b0};  // Next bit to the top
        end
    end

    assign ser_bit = shreg[`TX_NIBBLE_W-1];  // First bit first

    // Load once per quarter, the shift fills the rest
    a_load_period: assert property (@(posedge mdll_clk) disable iff (rst)
        load |=> !load[*(`TX_NIBBLE_W-1)])
        else $error("Quarter-rate load closer than one nibble apart");

endmodule

`default_nettype wire

// File: source/tx_skew_driver.sv
`timescale 1ns/1ps

`default_nettype none

`include "tx_params.svh"

module tx_skew_driver (
    input wire logic mdll_clk,  // Bit-rate clock
    input wire logic rst,       // Sync reset, active high
    input wire logic ser_bit,   // Serial bit from the quarter-rate stage
    tx_ctrl_if.sink ctrl,       // Skew code and driver controls
    output logic dout_p,        // Data output, positive leg
    output logic dout_n         // Data output, negative leg
);
    import tx_pkg::*;

    delay_t                   code_q;    // Active skew code
    logic [`TX_DELAY_MAX-1:0] dly_line;  // Registered stages behind the input
    logic [`TX_DELAY_MAX:0]   taps;      // 8 taps, tap 0 undelayed
    logic                     bit_sel;   // Bit at the chosen tap
    logic                     bit_pol;   // After polarity swap

    // Code register, stands in for the interpolator setting
    always_ff @(posedge mdll_clk) begin
        if (rst) begin
            code_q <= '0;
        end else if (ctrl.delay_valid) begin
            code_q <= ctrl.delay_code;
        end
    end

    // Delay line, one bit slot per stage
    always_ff @(posedge mdll_clk) begin
        dly_line <= {dly_line[`TX_DELAY_MAX-2:0], ser_bit};
    end

    assign taps = {dly_line, ser_bit};
    assign bit_sel = taps[code_q];        // d slots of skew
    assign bit_pol = bit_sel ^ ctrl.pol_inv;

    // Output driver
    // negative leg derived here instead of a second mux chain
    always_ff @(posedge mdll_clk) begin
        if (rst) begin
            dout_p <= 1'b0;
            dout_n <= 1'b0;
        end else if (!ctrl.drv_en) begin
            dout_p <= 1'b0;  // Both legs parked low
            dout_n <= 1'b0;
        end else begin
            dout_p <= bit_pol;
            dout_n <= ~bit_pol;
        end
    end

    // Enabled driver always shows a differential pair
    a_diff_pair: assert property (@(posedge mdll_clk) disable iff (rst)
        ctrl.drv_en |=> (dout_p != dout_n))
        else $error("dout_p equals dout_n while driver enabled");

endmodule

`default_nettype wire

// File: source/tx_top.sv
`timescale 1ns/1ps

`default_nettype none

module tx_top (
    input wire logic mdll_clk,               // Bit-rate clock from the MDLL
    input wire logic rst,                    // Sync reset, active high
    input wire tx_pkg::word_t din,           // Parallel word, presented on word_req
    output logic word_req,                   // Next-word strobe to the source
    input wire tx_pkg::delay_t delay_code,   // Skew code in bit slots
    input wire logic delay_valid,            // Strobe to take delay_code
    input wire logic drv_en,                 // Output driver enable
    input wire logic pol_inv,                // Swap output legs
    output logic dout_p,                     // Data output +
    output logic dout_n                      // Data output -
);
    import tx_pkg::*;

    slot_t   slot;     // Bit slot, shared by both mux stages
    nibble_t nibble;   // Half-rate to quarter-rate
    logic    ser_bit;  // Quarter-rate to skew stage

    // Control bundle, source side fed from the pins
    tx_ctrl_if ctrl ();

    assign ctrl.delay_code = delay_code;
    assign ctrl.delay_valid = delay_valid;
    assign ctrl.drv_en = drv_en;
    assign ctrl.pol_inv = pol_inv;

    // Slot counter and word request
    tx_clk_div clk_div_0 (
        .mdll_clk(mdll_clk),
        .rst(rst),
        .slot(slot),
        .word_req(word_req)
    );

    // 16 to 4, reorders into send order
    hr_16t4_mux hr_mux_16t4_0 (
        .mdll_clk(mdll_clk),
        .rst(rst),
        .din(din),
        .slot(slot),
        .nibble(nibble)
    );

    // 4 to 1 shift-out
    qr_4t1_mux qr_mux_4t1_0 (
        .mdll_clk(mdll_clk),
        .rst(rst),
        .nibble(nibble),
        .slot(slot),
        .ser_bit(ser_bit)
    );

    // Bit skew and differential driver
    tx_skew_driver skew_drv_0 (
        .mdll_clk(mdll_clk),
        .rst(rst),
        .ser_bit(ser_bit),
        .ctrl(ctrl.sink),
        .dout_p(dout_p),
        .dout_n(dout_n)
    );

endmodule

`default_nettype wire

// File: verif/tx_top_tb.sv
`timescale 1ns/1ps

`include "tx_params.svh"

module tx_top_tb;
    import tx_pkg::*;

    localparam int N_ROWS = 16;
    localparam int REQ_TIMEOUT = 40;      // Cycles to wait for word_req
    localparam int WORD_CYC = `TX_WORD_W;  // Bit slots per word

    // Word bit carried by each serial slot, first slot first
    localparam int SEND_ORDER [16] = '{15, 11, 7, 3, 14, 10, 6, 2,
                                       13, 9, 5, 1, 12, 8, 4, 0};

    // One stimulus row, word is replaced when rnd is set
    typedef struct packed {
        word_t  word;
        delay_t dly;
        logic   pol;
        logic   en;
        logic   rnd;
    } row_t;

    logic   mdll_clk;
    logic   rst;
    word_t  din;
    logic   word_req;
    delay_t delay_code;
    logic   delay_valid;
    logic   drv_en;
    logic   pol_inv;
    logic   dout_p;
    logic   dout_n;

    row_t   rows [N_ROWS];
    integer seed = 32'h492a2d5f;
    int     errors = 0;
    int     tests = 0;
    int     failed_tests = 0;
    delay_t cur_dly;  // Code last strobed into the DUT

    tx_top dut (
        .mdll_clk(mdll_clk),
        .rst(rst),
        .din(din),
        .word_req(word_req),
        .delay_code(delay_code),
        .delay_valid(delay_valid),
        .drv_en(drv_en),
        .pol_inv(pol_inv),
        .dout_p(dout_p),
        .dout_n(dout_n)
    );

    initial mdll_clk = 1'b0;
    always #20 mdll_clk = ~mdll_clk;  // 40 ns bit slot

    // Serial stream of a word, bit 15 of the result goes out first
    function automatic logic [15:0] send_stream(input word_t w);
        logic [15:0] s;
        for (int j = 0; j < 16; j++) begin
            s[15-j] = w[SEND_ORDER[j]];
        end
        return s;
    endfunction

    // Single-bit compare, error line names the signal
    task automatic check_bit(input string name, input string where,
                             input logic exp, input logic got);
        assert (got === exp) else begin
            $display("Mismatch %s at %s: expected %h got %h", name, where, exp, got);
            errors++;
        end
    endtask

    task automatic fill_table();
        rows[0]  = '{16'h8000, 3'd0, 1'b0, 1'b1, 1'b0};
        rows[1]  = '{16'h0001, 3'd0, 1'b0, 1'b1, 1'b0};
        rows[2]  = '{16'hA5C3, 3'd0, 1'b0, 1'b1, 1'b0};
        rows[3]  = '{16'h0000, 3'd0, 1'b0, 1'b1, 1'b1};
        rows[4]  = '{16'h0000, 3'd0, 1'b0, 1'b1, 1'b1};
        rows[5]  = '{16'hA5C3, 3'd1, 1'b0, 1'b1, 1'b0};
        rows[6]  = '{16'h0000, 3'd2, 1'b0, 1'b1, 1'b1};
        rows[7]  = '{16'h0000, 3'd3, 1'b0, 1'b1, 1'b1};
        rows[8]  = '{16'hA5C3, 3'd4, 1'b0, 1'b1, 1'b0};
        rows[9]  = '{16'h0000, 3'd5, 1'b0, 1'b1, 1'b1};
        rows[10] = '{16'h0000, 3'd6, 1'b0, 1'b1, 1'b1};
        rows[11] = '{16'hA5C3, 3'd7, 1'b0, 1'b1, 1'b0};
        rows[12] = '{16'hA5C3, 3'd0, 1'b1, 1'b1, 1'b0};  // Legs swapped
        rows[13] = '{16'h0000, 3'd3, 1'b1, 1'b1, 1'b1};
        rows[14] = '{16'hFFFF, 3'd0, 1'b0, 1'b0, 1'b0};  // Driver off
        rows[15] = '{16'h0000, 3'd0, 1'b0, 1'b1, 1'b1};
        for (int i = 0; i < N_ROWS; i++) begin
            if (rows[i].rnd) begin
                rows[i].word = word_t'($random(seed));
            end
        end
    endtask

    // Returns at the falling edge where word_req is seen high
    task automatic wait_req(output bit seen);
        int n;
        seen = 1'b0;
        n = 0;
        while (!seen && n < REQ_TIMEOUT) begin
            @(negedge mdll_clk);
            n++;
            if (word_req) seen = 1'b1;
        end
    endtask

    // Reset values, then the first request 15 cycles after release
    task automatic test_reset();
        int err0;
        err0 = errors;
        @(negedge mdll_clk);
        check_bit("word_req", "reset", 1'b0, word_req);
        check_bit("dout_p", "reset", 1'b0, dout_p);
        check_bit("dout_n", "reset", 1'b0, dout_n);
        @(negedge mdll_clk);
        rst = 1'b0;  // Two reset edges seen
        for (int k = 1; k <= 15; k++) begin
            @(negedge mdll_clk);
            check_bit("word_req", $sformatf("cycle %0d after reset", k), k == 15, word_req);
            check_bit("dout_p", "driver off", 1'b0, dout_p);
            check_bit("dout_n", "driver off", 1'b0, dout_n);
        end
        tests++;
        if (errors != err0) failed_tests++;
        $display("Test reset and first word_req: %s", errors == err0 ? "ok" : "FAIL");
    endtask

    // One-cycle pulse every word time
    task automatic test_req_period();
        int err0;
        err0 = errors;
        for (int k = 1; k <= 3 * WORD_CYC; k++) begin
            @(negedge mdll_clk);
            check_bit("word_req", $sformatf("period cycle %0d", k), (k % WORD_CYC) == 0,
                      word_req);
        end
        tests++;
        if (errors != err0) failed_tests++;
        $display("Test word_req period: %s", errors == err0 ? "ok" : "FAIL");
    endtask

    task automatic run_row(input int r);
        row_t        row;
        bit          seen;
        int          err0;
        int          lat;
        logic [15:0] stream;
        logic        exp_p;
        logic        exp_n;
        row = rows[r];
        err0 = errors;
        lat = `TX_LAT_BASE + int'(row.dly);
        drv_en = row.en;
        pol_inv = row.pol;
        if (row.dly != cur_dly) begin
            delay_code = row.dly;
            delay_valid = 1'b1;  // One-cycle strobe
            @(negedge mdll_clk);
            delay_valid = 1'b0;
            cur_dly = row.dly;
        end
        repeat (2 * WORD_CYC) @(negedge mdll_clk);  // New latency settles
        wait_req(seen);
        assert (seen) else begin
            $display("Row %0d: no word_req within %0d cycles", r, REQ_TIMEOUT);
            errors++;
        end
        if (seen) begin
            din = row.word;  // Sampled at E0, the next rising edge
            stream = send_stream(row.word);
            // First bit valid after E0+lat, checked before E0+lat+1
            repeat (lat + 1) @(negedge mdll_clk);
            for (int j = 0; j < 16; j++) begin
                if (j > 0) @(negedge mdll_clk);
                exp_p = row.en ? (stream[15-j] ^ row.pol) : 1'b0;
                exp_n = row.en ? ~(stream[15-j] ^ row.pol) : 1'b0;
                check_bit("dout_p", $sformatf("row %0d bit %0d", r, j), exp_p, dout_p);
                check_bit("dout_n", $sformatf("row %0d bit %0d", r, j), exp_n, dout_n);
            end
        end
        tests++;
        if (errors != err0) failed_tests++;
        $display("Row %0d word %h delay %0d pol %0b en %0b: %s", r, row.word, row.dly,
                 row.pol, row.en, errors == err0 ? "ok" : "FAIL");
    endtask

    initial begin
        rst = 1'b1;
        din = '0;
        delay_code = '0;
        delay_valid = 1'b0;
        drv_en = 1'b0;
        pol_inv = 1'b0;
        cur_dly = '0;  // DUT code after reset
        fill_table();
        test_reset();
        test_req_period();
        for (int r = 0; r < N_ROWS; r++) begin
            run_row(r);
        end
        $display("Tests: %0d run, %0d failed, %0d check errors", tests, failed_tests, errors);
        if (failed_tests == 0 && errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+source
source/tx_pkg.sv
source/tx_ctrl_if.sv
source/tx_clk_div.sv
source/hr_16t4_mux.sv
source/qr_4t1_mux.sv
source/tx_skew_driver.sv
source/tx_top.sv
verif/tx_top_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the transmitter testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

if ! command -v verilator > /dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

verilator --binary --timing --assert -Wno-fatal \
    --top-module tx_top_tb \
    --Mdir obj_dir \
    -f files.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out="$(./obj_dir/Vtx_top_tb)"
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "sim passed" <<< "$out"; then
    exit 0
else
    exit 1
fi
